// ==== common/egress_q_pkg.sv ====
/*
 * Shared sizes, types and state encodings for the egress queueing subsystem.
 * Imported by every design module, by the interfaces and by the testbench.
 */
package egress_q_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int NUM_PORTS       = 2;
    localparam int NUM_BUFFERS     = 8;
    localparam int BUF_WORDS       = 8;
    localparam int WORD_WID        = 32;
    localparam int OUT_CREDIT_INIT = 4;

    localparam int PORT_WID     = $clog2(NUM_PORTS);
    localparam int BUF_ID_WID   = $clog2(NUM_BUFFERS);
    localparam int OFS_WID      = $clog2(BUF_WORDS);
    localparam int LEN_WID      = OFS_WID + 1;
    localparam int MEM_ADDR_WID = BUF_ID_WID + OFS_WID;
    localparam int MEM_DEPTH    = NUM_BUFFERS * BUF_WORDS;

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [PORT_WID-1:0]     port_t;
    typedef logic [BUF_ID_WID-1:0]   buf_id_t;
    typedef logic [LEN_WID-1:0]      len_t;
    typedef logic [WORD_WID-1:0]     word_t;
    typedef logic [OFS_WID-1:0]      ofs_t;
    // Buffer number in the upper bits, word offset in the lower bits
    typedef logic [MEM_ADDR_WID-1:0] mem_addr_t;

    typedef logic [$clog2(NUM_BUFFERS+1)-1:0]     buf_cnt_t;
    typedef logic [$clog2(OUT_CREDIT_INIT+1)-1:0] out_cred_t;

    typedef enum logic {
        CTRL_INIT,
        CTRL_RUN
    } ctrl_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_XFER,
        RD_FREE
    } rd_state_t;

endpackage : egress_q_pkg

// ==== common/pkt_desc_if.sv ====
/*
 * Packet descriptor channel: buffer number, length and destination port.
 * The writer pushes into the controller without handshake; the controller
 * offers descriptors to the reader and holds them until a one-cycle ack.
 */
interface pkt_desc_if ();
    import egress_q_pkg::*;

    logic    valid;
    logic    ack;
    buf_id_t buf_id;
    len_t    len;
    port_t   port;

    // Push side, no ack
    modport writer   (output valid, buf_id, len, port);
    modport ctrl_in  (input  valid, buf_id, len, port);

    // Pop side, held until ack
    modport ctrl_out (output valid, buf_id, len, port, input  ack);
    modport reader   (input  valid, buf_id, len, port, output ack);

endinterface : pkt_desc_if

// ==== common/buf_mem_if.sv ====
/*
 * Buffer memory access: one write port used by the writer and one read
 * port used by the reader. Read data follows rd_en by exactly one cycle.
 */
interface buf_mem_if ();
    import egress_q_pkg::*;

    // Write port
    logic      wr_en;
    mem_addr_t wr_addr;
    word_t     wr_data;

    // Read port
    logic      rd_en;
    mem_addr_t rd_addr;
    word_t     rd_data;

    modport mem (
        input  wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr,
        output rd_data
    );

    modport writer (output wr_en, wr_addr, wr_data);

    modport reader (output rd_en, rd_addr, input rd_data);

endinterface : buf_mem_if

// ==== hdl/buf_mem.sv ====
/*
 * Packet buffer memory, one write port and one read port.
 * Reads are registered, so data appears one cycle after rd_en.
 */
module buf_mem (
    input  logic   clk,
    buf_mem_if.mem mem_if
);
    import egress_q_pkg::*;

    word_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_if.wr_en) begin
            mem[mem_if.wr_addr] <= mem_if.wr_data;
        end
    end

    // Old contents on a same-address collision
    always_ff @(posedge clk) begin
        if (mem_if.rd_en) begin
            mem_if.rd_data <= mem[mem_if.rd_addr];
        end
    end

endmodule : buf_mem

// ==== egress_q/egress_q_ctrl.sv ====
/*
 * Queue controller. Keeps the free-buffer list, one descriptor FIFO per
 * output port and a round-robin choice between the ports. After reset it
 * loads the free list with every buffer number, then raises o_init_done.
 * Each released buffer returns one ingress credit a cycle later.
 */
module egress_q_ctrl (
    input  logic                  clk,
    input  logic                  i_rst_n,

    pkt_desc_if.ctrl_in           desc_wr,
    pkt_desc_if.ctrl_out          desc_rd,

    output egress_q_pkg::buf_id_t o_free_buf,
    input  logic                  i_alloc,
    input  logic                  i_release,
    input  egress_q_pkg::buf_id_t i_release_buf,

    output logic                  o_in_credit,
    output logic                  o_init_done
);
    import egress_q_pkg::*;

    ctrl_state_t state;

    // Free list
    buf_id_t  free_list [NUM_BUFFERS];
    buf_id_t  free_rd;
    buf_id_t  free_wr;
    buf_cnt_t free_cnt;
    logic     fl_wr_en;
    buf_id_t  fl_wr_data;

    // Descriptor queues, as deep as the number of buffers
    buf_id_t  q_buf [NUM_PORTS][NUM_BUFFERS];
    len_t     q_len [NUM_PORTS][NUM_BUFFERS];
    buf_id_t  q_rd  [NUM_PORTS];
    buf_id_t  q_wr  [NUM_PORTS];
    buf_cnt_t q_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0] q_push;
    logic [NUM_PORTS-1:0] q_pop;
    logic [NUM_PORTS-1:0] q_nonempty;

    // Round robin
    port_t rr_port;
    port_t pick_port;
    port_t sel_port;
    logic  sel_valid;
    logic  pick;

    // ------------------------------
    // Free list
    // ------------------------------
    assign fl_wr_en    = (state == CTRL_INIT) || i_release;
    assign fl_wr_data  = (state == CTRL_INIT) ? free_wr : i_release_buf;
    assign o_free_buf  = free_list[free_rd];
    assign o_init_done = (state == CTRL_RUN);

    always_ff @(posedge clk) begin
        if (fl_wr_en) begin
            free_list[free_wr] <= fl_wr_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= CTRL_INIT;
            free_rd     <= '0;
            free_wr     <= '0;
            free_cnt    <= '0;
            o_in_credit <= 1'b0;
        end else begin
            o_in_credit <= i_release;
            if (fl_wr_en) begin
                free_wr <= free_wr + buf_id_t'(1);
            end
            if (i_alloc) begin
                free_rd <= free_rd + buf_id_t'(1);
            end
            if (fl_wr_en && !i_alloc) begin
                free_cnt <= free_cnt + buf_cnt_t'(1);
            end else if (!fl_wr_en && i_alloc) begin
                free_cnt <= free_cnt - buf_cnt_t'(1);
            end
            // Last buffer number loaded ends initialization
            if (state == CTRL_INIT && free_wr == buf_id_t'(NUM_BUFFERS - 1)) begin
                state <= CTRL_RUN;
            end
        end
    end

    // ------------------------------
    // Descriptor queues
    // ------------------------------
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            q_push[p]     = desc_wr.valid && (desc_wr.port == port_t'(p));
            q_pop[p]      = desc_rd.ack && (sel_port == port_t'(p));
            q_nonempty[p] = (q_cnt[p] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (desc_wr.valid) begin
            q_buf[desc_wr.port][q_wr[desc_wr.port]] <= desc_wr.buf_id;
            q_len[desc_wr.port][q_wr[desc_wr.port]] <= desc_wr.len;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                q_rd[p]  <= '0;
                q_wr[p]  <= '0;
                q_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (q_push[p]) begin
                    q_wr[p] <= q_wr[p] + buf_id_t'(1);
                end
                if (q_pop[p]) begin
                    q_rd[p] <= q_rd[p] + buf_id_t'(1);
                end
                if (q_push[p] && !q_pop[p]) begin
                    q_cnt[p] <= q_cnt[p] + buf_cnt_t'(1);
                end else if (!q_push[p] && q_pop[p]) begin
                    q_cnt[p] <= q_cnt[p] - buf_cnt_t'(1);
                end
            end
        end
    end

    // ------------------------------
    // Round-robin selection
    // ------------------------------
    // Favoured port first, otherwise the other one
    always_comb begin
        pick_port = rr_port;
        if (!q_nonempty[rr_port]) begin
            pick_port = port_t'(rr_port + port_t'(1));
        end
    end

    assign pick = !sel_valid && (q_nonempty != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sel_valid <= 1'b0;
            sel_port  <= '0;
            rr_port   <= '0;
        end else if (desc_rd.ack) begin
            sel_valid <= 1'b0;
            rr_port   <= port_t'(sel_port + port_t'(1));
        end else if (pick) begin
            sel_valid <= 1'b1;
            sel_port  <= pick_port;
        end
    end

    // Head of the chosen queue stays put until it is popped
    assign desc_rd.valid  = sel_valid;
    assign desc_rd.port   = sel_port;
    assign desc_rd.buf_id = q_buf[sel_port][q_rd[sel_port]];
    assign desc_rd.len    = q_len[sel_port][q_rd[sel_port]];

endmodule : egress_q_ctrl

// ==== egress_q/egress_q_writer.sv ====
/*
 * Ingress writer. Takes the free buffer on the first word of a packet,
 * writes each word straight into the buffer memory, and pushes one
 * descriptor to the controller in the cycle after the last word.
 */
module egress_q_writer (
    input  logic                  clk,
    input  logic                  i_rst_n,

    input  logic                  i_in_valid,
    input  egress_q_pkg::word_t   i_in_data,
    input  logic                  i_in_last,
    input  egress_q_pkg::port_t   i_in_port,

    input  egress_q_pkg::buf_id_t i_free_buf,
    output logic                  o_alloc,

    buf_mem_if.writer             mem_wr,
    pkt_desc_if.writer            desc_wr
);
    import egress_q_pkg::*;

    logic    in_pkt;
    logic    first;
    buf_id_t cur_buf;
    port_t   cur_port;
    ofs_t    ofs;
    buf_id_t wr_buf;
    ofs_t    wr_ofs;
    port_t   wr_port;

    // First word uses the free-list head directly
    assign first   = i_in_valid && !in_pkt;
    assign wr_buf  = first ? i_free_buf : cur_buf;
    assign wr_ofs  = first ? '0 : ofs;
    assign wr_port = first ? i_in_port : cur_port;
    assign o_alloc = first;

    assign mem_wr.wr_en   = i_in_valid;
    assign mem_wr.wr_addr = {wr_buf, wr_ofs};
    assign mem_wr.wr_data = i_in_data;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_pkt <= 1'b0;
            ofs    <= '0;
        end else if (i_in_valid) begin
            in_pkt <= !i_in_last;
            ofs    <= wr_ofs + ofs_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (first) begin
            cur_buf  <= i_free_buf;
            cur_port <= i_in_port;
        end
    end

    // ------------------------------
    // Descriptor push
    // ------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            desc_wr.valid <= 1'b0;
        end else begin
            desc_wr.valid <= i_in_valid && i_in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid && i_in_last) begin
            desc_wr.buf_id <= wr_buf;
            desc_wr.len    <= len_t'(wr_ofs) + len_t'(1);
            desc_wr.port   <= wr_port;
        end
    end

endmodule : egress_q_writer

// ==== egress_q/egress_q_reader.sv ====
/*
 * Egress reader. Takes one descriptor at a time, reads its words while the
 * destination port holds word credits, and frees the buffer afterwards.
 * A port without credits stalls the other port as well.
 */
module egress_q_reader (
    input  logic                                  clk,
    input  logic                                  i_rst_n,

    pkt_desc_if.reader                            desc_rd,
    buf_mem_if.reader                             mem_rd,

    input  logic [egress_q_pkg::NUM_PORTS-1:0]    i_out_credit,
    output logic [egress_q_pkg::NUM_PORTS-1:0]    o_out_valid,
    output egress_q_pkg::word_t                   o_out_data,
    output logic                                  o_out_last,

    output logic                                  o_release,
    output egress_q_pkg::buf_id_t                 o_release_buf
);
    import egress_q_pkg::*;

    rd_state_t state;
    buf_id_t   cur_buf;
    len_t      cur_len;
    port_t     cur_port;
    ofs_t      ofs;
    out_cred_t cred [NUM_PORTS];
    logic      rd_issue;
    logic      last_word;

    assign desc_rd.ack = (state == RD_IDLE) && desc_rd.valid;
    assign rd_issue    = (state == RD_XFER) && (cred[cur_port] != '0);
    assign last_word   = ((len_t'(ofs) + len_t'(1)) == cur_len);

    assign mem_rd.rd_en   = rd_issue;
    assign mem_rd.rd_addr = {cur_buf, ofs};

    assign o_out_data    = mem_rd.rd_data;
    assign o_release     = (state == RD_FREE);
    assign o_release_buf = cur_buf;

    // ------------------------------
    // Read FSM
    // ------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= RD_IDLE;
            ofs   <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (desc_rd.valid) begin
                        state <= RD_XFER;
                        ofs   <= '0;
                    end
                end
                RD_XFER: begin
                    if (rd_issue) begin
                        ofs <= ofs + ofs_t'(1);
                        if (last_word) begin
                            state <= RD_FREE;
                        end
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (desc_rd.ack) begin
            cur_buf  <= desc_rd.buf_id;
            cur_len  <= desc_rd.len;
            cur_port <= desc_rd.port;
        end
    end

    // Output strobes line up with the registered memory read
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= '0;
            o_out_last  <= 1'b0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                o_out_valid[p] <= rd_issue && (cur_port == port_t'(p));
            end
            o_out_last <= rd_issue && last_word;
        end
    end

    // ------------------------------
    // Word credits per port
    // ------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                cred[p] <= out_cred_t'(OUT_CREDIT_INIT);
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (i_out_credit[p] && !(rd_issue && cur_port == port_t'(p))) begin
                    cred[p] <= cred[p] + out_cred_t'(1);
                end else if (!i_out_credit[p] && rd_issue && cur_port == port_t'(p)) begin
                    cred[p] <= cred[p] - out_cred_t'(1);
                end
            end
        end
    end

endmodule : egress_q_reader

// ==== hdl/egress_qs.sv ====
/*
 * Egress queueing subsystem top level. Packets enter on one ingress
 * stream under per-packet credits and leave on one of two output ports
 * under per-word credits. The sender waits for o_init_done before sending.
 */
module egress_qs (
    input  logic                               clk,
    input  logic                               i_rst_n,

    input  logic                               i_in_valid,
    input  egress_q_pkg::word_t                i_in_data,
    input  logic                               i_in_last,
    input  egress_q_pkg::port_t                i_in_port,
    output logic                               o_in_credit,

    output logic [egress_q_pkg::NUM_PORTS-1:0] o_out_valid,
    output egress_q_pkg::word_t                o_out_data,
    output logic                               o_out_last,
    input  logic [egress_q_pkg::NUM_PORTS-1:0] i_out_credit,

    output logic                               o_init_done
);
    import egress_q_pkg::*;

    buf_id_t free_buf;
    logic    alloc;
    logic    release_en;
    buf_id_t release_buf;

    pkt_desc_if desc_wr ();
    pkt_desc_if desc_rd ();
    buf_mem_if  mem_if ();

    // ------------------------------
    // Control
    // ------------------------------
    egress_q_ctrl i_egress_q_ctrl (
        .clk           ( clk ),
        .i_rst_n       ( i_rst_n ),
        .desc_wr       ( desc_wr ),
        .desc_rd       ( desc_rd ),
        .o_free_buf    ( free_buf ),
        .i_alloc       ( alloc ),
        .i_release     ( release_en ),
        .i_release_buf ( release_buf ),
        .o_in_credit   ( o_in_credit ),
        .o_init_done   ( o_init_done )
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    egress_q_writer i_egress_q_writer (
        .clk        ( clk ),
        .i_rst_n    ( i_rst_n ),
        .i_in_valid ( i_in_valid ),
        .i_in_data  ( i_in_data ),
        .i_in_last  ( i_in_last ),
        .i_in_port  ( i_in_port ),
        .i_free_buf ( free_buf ),
        .o_alloc    ( alloc ),
        .mem_wr     ( mem_if ),
        .desc_wr    ( desc_wr )
    );

    egress_q_reader i_egress_q_reader (
        .clk           ( clk ),
        .i_rst_n       ( i_rst_n ),
        .desc_rd       ( desc_rd ),
        .mem_rd        ( mem_if ),
        .i_out_credit  ( i_out_credit ),
        .o_out_valid   ( o_out_valid ),
        .o_out_data    ( o_out_data ),
        .o_out_last    ( o_out_last ),
        .o_release     ( release_en ),
        .o_release_buf ( release_buf )
    );

    buf_mem i_buf_mem (
        .clk    ( clk ),
        .mem_if ( mem_if )
    );

endmodule : egress_qs

// ==== testbench/egress_qs_props.sv ====
/*
 * Concurrent checks on the queue controller, bound into every instance of
 * egress_q_ctrl. Covers free-list occupancy, the hold-until-ack rule on
 * the reader-side descriptor, and ingress credits during initialization.
 */
module egress_qs_props (
    input logic                      clk,
    input logic                      i_rst_n,
    input egress_q_pkg::ctrl_state_t state,
    input egress_q_pkg::buf_cnt_t    free_cnt,
    input logic                      rd_valid,
    input logic                      rd_ack,
    input egress_q_pkg::buf_id_t     rd_buf,
    input egress_q_pkg::len_t        rd_len,
    input egress_q_pkg::port_t       rd_port,
    input logic                      o_in_credit
);
    timeunit 1ns;
    timeprecision 1ps;
    import egress_q_pkg::*;

    // Free list never holds more entries than there are buffers
    free_cnt_bound: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        free_cnt <= buf_cnt_t'(NUM_BUFFERS)
    ) else $error("free list count %0d above %0d", free_cnt, NUM_BUFFERS);

    // Offered descriptor stays put until the reader takes it
    desc_rd_hold: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (rd_valid && !rd_ack) |=> (rd_valid && $stable({rd_buf, rd_len, rd_port}))
    ) else $error("desc_rd changed or dropped before ack");

    init_no_credit: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (state == CTRL_INIT) |-> !o_in_credit
    ) else $error("ingress credit returned during free-list init");

endmodule : egress_qs_props

bind egress_q_ctrl egress_qs_props u_props (
    .clk         ( clk ),
    .i_rst_n     ( i_rst_n ),
    .state       ( state ),
    .free_cnt    ( free_cnt ),
    .rd_valid    ( desc_rd.valid ),
    .rd_ack      ( desc_rd.ack ),
    .rd_buf      ( desc_rd.buf_id ),
    .rd_len      ( desc_rd.len ),
    .rd_port     ( desc_rd.port ),
    .o_in_credit ( o_in_credit )
);

// ==== testbench/tb_egress_qs.sv ====
/*
 * Testbench for the egress queueing subsystem. A table of tests sets packet
 * counts, lengths, destinations and sink pauses. Payloads come from an
 * xorshift generator, a per-port scoreboard checks every output word, and
 * models of both credit loops track the ingress and egress credits.
 */
module tb_egress_qs;
    timeunit 1ns;
    timeprecision 1ps;
    import egress_q_pkg::*;

    typedef struct packed {
        logic [7:0] num_pkts;
        logic [3:0] len_base;
        logic [3:0] len_step;
        logic [7:0] dest_pat;
        logic       serial;
        logic       need_wait;
        port_t      hold_port;
        logic [7:0] hold_cycles;
    } test_row_t;

    localparam int NUM_TESTS   = 4;
    localparam int DRAIN_LIMIT = 200;

    // Length of packet i is ((base - 1 + i * step) mod 8) + 1
    // Port of packet i is bit (i mod 8) of the destination pattern
    localparam test_row_t TESTS [NUM_TESTS] = '{
        // pkts  base  step  dest   serial need_wait port  hold
        '{8'd8,  4'd1, 4'd1, 8'hF0, 1'b1,  1'b0,     1'b0, 8'd0},
        '{8'd16, 4'd3, 4'd5, 8'h96, 1'b0,  1'b0,     1'b0, 8'd0},
        '{8'd12, 4'd4, 4'd0, 8'h00, 1'b0,  1'b1,     1'b0, 8'd60},
        '{8'd6,  4'd2, 4'd3, 8'hCE, 1'b0,  1'b0,     1'b1, 8'd50}
    };

    string names [NUM_TESTS] = '{
        "single packets of each length",
        "mixed stream to both ports",
        "ingress credit exhaustion",
        "withheld egress credits"
    };

    logic                 clk;
    logic                 i_rst_n;
    logic                 i_in_valid;
    word_t                i_in_data;
    logic                 i_in_last;
    port_t                i_in_port;
    logic                 o_in_credit;
    logic [NUM_PORTS-1:0] o_out_valid;
    word_t                o_out_data;
    logic                 o_out_last;
    logic [NUM_PORTS-1:0] i_out_credit;
    logic                 o_init_done;

    int          errors        = 0;
    int          tests_failed  = 0;
    int          in_credits    = NUM_BUFFERS;
    int          credit_pulses = 0;
    int          cycle         = 0;
    int          pending [NUM_PORTS];
    int          hold_until [NUM_PORTS];
    logic [31:0] rng           = 32'd37738;

    // Expected words per port with the last flag in the top bit
    logic [WORD_WID:0] exp_q [NUM_PORTS][$];

    egress_qs UUT (
        .clk          ( clk ),
        .i_rst_n      ( i_rst_n ),
        .i_in_valid   ( i_in_valid ),
        .i_in_data    ( i_in_data ),
        .i_in_last    ( i_in_last ),
        .i_in_port    ( i_in_port ),
        .o_in_credit  ( o_in_credit ),
        .o_out_valid  ( o_out_valid ),
        .o_out_data   ( o_out_data ),
        .o_out_last   ( o_out_last ),
        .i_out_credit ( i_out_credit ),
        .o_init_done  ( o_init_done )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pkt_len(input int t, input int i);
        return ((int'(TESTS[t].len_base) - 1 + i * int'(TESTS[t].len_step)) % BUF_WORDS) + 1;
    endfunction

    function automatic int timeout_cycles();
        int words;
        words = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < int'(TESTS[t].num_pkts); i++) begin
                words += pkt_len(t, i);
            end
        end
        return words * 4 + 200;
    endfunction

    function automatic bit drained();
        return (exp_q[0].size() == 0) && (exp_q[1].size() == 0) &&
               (pending[0] == 0) && (pending[1] == 0) && (in_credits == NUM_BUFFERS);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic report_test(input int t, input string name, input int start_err);
        int n;
        n = errors - start_err;
        if (n != 0) begin
            tests_failed++;
        end
        $display("Test %0d, %s: %0s, %0d errors", t, name, (n == 0) ? "ok" : "failed", n);
    endtask

    // ------------------------------
    // Sink and monitor
    // ------------------------------
    // One word credit back per cycle once the pause has ended
    initial begin
        i_out_credit = '0;
        pending      = '{0, 0};
        hold_until   = '{0, 0};
        forever begin
            @(posedge clk);
            #2;
            for (int p = 0; p < NUM_PORTS; p++) begin
                i_out_credit[p] = 1'b0;
                if (pending[p] > 0 && cycle >= hold_until[p]) begin
                    i_out_credit[p] = 1'b1;
                    pending[p]--;
                end
            end
        end
    end

    always @(negedge clk) begin : monitor
        logic [WORD_WID:0] exp_word;
        if (o_in_credit) begin
            in_credits++;
            credit_pulses++;
        end
        if (o_out_valid == '0) begin
            check_value("o_out_last", 1'b0, o_out_last);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (o_out_valid[p]) begin
                pending[p]++;
                if (pending[p] > OUT_CREDIT_INIT) begin
                    $display("Port %0d showed %0d words without credit return, limit %0d",
                             p, pending[p], OUT_CREDIT_INIT);
                    errors++;
                end
                if (exp_q[p].size() == 0) begin
                    $display("Unexpected word %h on port %0d at %0t", o_out_data, p, $time);
                    errors++;
                end else begin
                    exp_word = exp_q[p].pop_front();
                    check_value("o_out_data", exp_word[WORD_WID-1:0], o_out_data);
                    check_value("o_out_last", exp_word[WORD_WID], o_out_last);
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = timeout_cycles();
        while (cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic send_packet(input port_t port, input int len);
        for (int i = 0; i < len; i++) begin
            rng        = xorshift32(rng);
            i_in_valid = 1'b1;
            i_in_data  = rng;
            i_in_last  = (i == len - 1);
            i_in_port  = port;
            exp_q[port].push_back({i_in_last, rng});
            @(posedge clk);
            #2;
        end
        i_in_valid = 1'b0;
        i_in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (n < DRAIN_LIMIT) begin
            @(negedge clk);
            #1;
            if (drained()) begin
                break;
            end
            n++;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                $display("Packets missing: %0d words never arrived on port %0d",
                         exp_q[p].size(), p);
                errors++;
                exp_q[p].delete();
            end
        end
        if (in_credits != NUM_BUFFERS) begin
            $display("Ingress credits not returned: sender holds %0d of %0d",
                     in_credits, NUM_BUFFERS);
            errors++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic reset_and_init();
        int n;
        int start_err;
        start_err = errors;
        i_rst_n   = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        n       = 0;
        while (!o_init_done && n < 4 * NUM_BUFFERS) begin
            check_value("o_out_valid", '0, o_out_valid);
            check_value("o_out_last", '0, o_out_last);
            check_value("o_in_credit", '0, o_in_credit);
            @(posedge clk);
            #2;
            n++;
        end
        check_value("init cycles", NUM_BUFFERS, n);
        report_test(0, "reset and init", start_err);
    endtask

    task automatic run_test(input int t);
        int    start_err;
        int    start_pulses;
        int    waits;
        port_t port;
        start_err    = errors;
        start_pulses = credit_pulses;
        waits        = 0;
        @(negedge clk);
        if (TESTS[t].hold_cycles != '0) begin
            hold_until[TESTS[t].hold_port] = cycle + int'(TESTS[t].hold_cycles);
        end
        @(posedge clk);
        #2;
        for (int i = 0; i < int'(TESTS[t].num_pkts); i++) begin
            port = TESTS[t].dest_pat[i % 8];
            // Sender needs a packet credit before the first word
            while (in_credits == 0) begin
                waits++;
                @(posedge clk);
                #2;
            end
            in_credits--;
            send_packet(port, pkt_len(t, i));
            if (TESTS[t].serial) begin
                wait_drain();
            end
        end
        wait_drain();
        check_value("o_in_credit pulses", TESTS[t].num_pkts, credit_pulses - start_pulses);
        if (TESTS[t].need_wait && waits == 0) begin
            $display("Sender never ran out of ingress credits in test %0d", t + 1);
            errors++;
        end
        report_test(t + 1, names[t], start_err);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        i_rst_n    = 1'b0;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        i_in_last  = 1'b0;
        i_in_port  = '0;
        reset_and_init();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 NUM_TESTS + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_egress_qs

// ==== tb.f ====
common/egress_q_pkg.sv
common/pkt_desc_if.sv
common/buf_mem_if.sv
hdl/buf_mem.sv
egress_q/egress_q_ctrl.sv
egress_q/egress_q_writer.sv
egress_q/egress_q_reader.sv
hdl/egress_qs.sv
testbench/egress_qs_props.sv
testbench/tb_egress_qs.sv

// ==== Bender.yml ====
package:
  name: egress_qs

sources:
  # Design
  - common/egress_q_pkg.sv
  - common/pkt_desc_if.sv
  - common/buf_mem_if.sv
  - hdl/buf_mem.sv
  - egress_q/egress_q_ctrl.sv
  - egress_q/egress_q_writer.sv
  - egress_q/egress_q_reader.sv
  - hdl/egress_qs.sv

  # Verification
  - target: test
    files:
      - testbench/egress_qs_props.sv
      - testbench/tb_egress_qs.sv
